/* vlog.f */
+incdir+include
hdl/wb_com_pkg.sv
hdl/wb_com_req_if.sv
hdl/wb_com_fifo.sv
hdl/wb_com_master.sv
hdl/wb_com_slave.sv
hdl/wb_com_top.sv
testbench/tb_wb_slave_model.sv
testbench/tb_wb_com.sv

/* Makefile */
# Verilator build and run for the Wishbone interconnect testbench
# Any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= tb_wb_com
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
BIN       := $(OBJ_DIR)/V$(TOP)
PASS_MSG  ?= Test OK

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status comes from the search for the pass line
run: compile
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_wb_com.sv */
// Testbench for the two-master two-slave Wishbone interconnect
`include "wb_com_params.svh"

module tb_wb_com;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int AW = `WB_COM_AWIDTH;
  localparam int DW = `WB_COM_DWIDTH;
  localparam int SW = `WB_COM_DWIDTH / 8;
  localparam int NUM_TESTS = 6;
  localparam logic [31:0] SEED = 32'h5d6b_4b4b;

  // Expected response of one request
  typedef struct packed {
    logic          err;
    logic          rd;
    logic [DW-1:0] dat;
  } rsp_t;

  logic          clk = 1'b0;
  logic          rst;
  logic [AW-1:0] m_addr [2];
  logic [DW-1:0] m_wdat [2];
  logic [SW-1:0] m_sel [2];
  logic          m_cyc [2];
  logic          m_stb [2];
  logic          m_we [2];
  logic [DW-1:0] m_rdat [2];
  logic          m_stall [2];
  logic          m_ack [2];
  logic          m_err [2];
  logic [AW-1:0] s_addr [2];
  logic [DW-1:0] s_wdat [2];
  logic [SW-1:0] s_sel [2];
  logic          s_cyc [2];
  logic          s_stb [2];
  logic          s_we [2];
  logic [DW-1:0] s_rdat [2];
  logic          s_stall [2];
  logic          s_ack [2];
  logic [2:0]    s0_extra;
  logic [31:0]   lat_state = SEED;
  logic [31:0]   data_state;
  logic [DW-1:0] ref_mem [logic [AW-1:0]];
  rsp_t          exp_q0 [$];
  rsp_t          exp_q1 [$];
  int            errors;
  int            stb_seen;

  always #4 clk = ~clk;

  wb_com_top i_dut (
    .clk_i(clk), .rst_i(rst),
    .m0_wb_addr_i(m_addr[0]), .m0_wb_dat_i(m_wdat[0]), .m0_wb_sel_i(m_sel[0]),
    .m0_wb_cyc_i(m_cyc[0]), .m0_wb_stb_i(m_stb[0]), .m0_wb_we_i(m_we[0]),
    .m0_wb_dat_o(m_rdat[0]), .m0_wb_stall_o(m_stall[0]),
    .m0_wb_ack_o(m_ack[0]), .m0_wb_err_o(m_err[0]),
    .m1_wb_addr_i(m_addr[1]), .m1_wb_dat_i(m_wdat[1]), .m1_wb_sel_i(m_sel[1]),
    .m1_wb_cyc_i(m_cyc[1]), .m1_wb_stb_i(m_stb[1]), .m1_wb_we_i(m_we[1]),
    .m1_wb_dat_o(m_rdat[1]), .m1_wb_stall_o(m_stall[1]),
    .m1_wb_ack_o(m_ack[1]), .m1_wb_err_o(m_err[1]),
    .s0_wb_addr_o(s_addr[0]), .s0_wb_dat_o(s_wdat[0]), .s0_wb_sel_o(s_sel[0]),
    .s0_wb_cyc_o(s_cyc[0]), .s0_wb_stb_o(s_stb[0]), .s0_wb_we_o(s_we[0]),
    .s0_wb_dat_i(s_rdat[0]), .s0_wb_stall_i(s_stall[0]), .s0_wb_ack_i(s_ack[0]),
    .s1_wb_addr_o(s_addr[1]), .s1_wb_dat_o(s_wdat[1]), .s1_wb_sel_o(s_sel[1]),
    .s1_wb_cyc_o(s_cyc[1]), .s1_wb_stb_o(s_stb[1]), .s1_wb_we_o(s_we[1]),
    .s1_wb_dat_i(s_rdat[1]), .s1_wb_stall_i(s_stall[1]), .s1_wb_ack_i(s_ack[1])
  );

  tb_wb_slave_model u_mem0 (
    .clk_i(clk), .rst_i(rst), .addr_i(s_addr[0]), .dat_i(s_wdat[0]), .sel_i(s_sel[0]),
    .cyc_i(s_cyc[0]), .stb_i(s_stb[0]), .we_i(s_we[0]), .rnd_i(lat_state[7:0]),
    .extra_lat_i(s0_extra), .dat_o(s_rdat[0]), .stall_o(s_stall[0]), .ack_o(s_ack[0])
  );

  tb_wb_slave_model u_mem1 (
    .clk_i(clk), .rst_i(rst), .addr_i(s_addr[1]), .dat_i(s_wdat[1]), .sel_i(s_sel[1]),
    .cyc_i(s_cyc[1]), .stb_i(s_stb[1]), .we_i(s_we[1]), .rnd_i(lat_state[15:8]),
    .extra_lat_i(3'd0), .dat_o(s_rdat[1]), .stall_o(s_stall[1]), .ack_o(s_ack[1])
  );

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Stall and latency draws for both memories
  always @(posedge clk) lat_state <= xorshift(lat_state);

  // Slave 0 owns 0x0xxx_xxxx and slave 1 owns 0x1xxx_xxxx
  function automatic logic is_mapped(input logic [AW-1:0] a);
    return a[AW-1:AW-4] inside {4'h0, 4'h1};
  endfunction

  // Old word with the selected bytes replaced
  function automatic logic [DW-1:0] merge_bytes(input logic [DW-1:0] old_w,
                                                input logic [DW-1:0] wdat,
                                                input logic [SW-1:0] sel);
    logic [DW-1:0] w;
    w = old_w;
    for (int b = 0; b < SW; b++) begin
      if (sel[b]) w[8*b +: 8] = wdat[8*b +: 8];
    end
    return w;
  endfunction

  function automatic int pending(input int m);
    return (m == 0) ? exp_q0.size() : exp_q1.size();
  endfunction

  task automatic next_rand(output logic [DW-1:0] v);
    data_state = xorshift(data_state);
    v = data_state;
  endtask

  task automatic check_data(input string what, input logic [DW-1:0] got,
                            input logic [DW-1:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %h expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
      errors++;
    end
  endtask

  // Response for the oldest outstanding request of master m
  task automatic check_rsp(input int m);
    rsp_t e;
    if (pending(m) == 0) begin
      $display("ERROR at %0t ns: master %0d answered with nothing outstanding", $time, m);
      errors++;
      return;
    end
    if (m == 0) e = exp_q0.pop_front();
    else e = exp_q1.pop_front();
    check_flag($sformatf("m%0d err", m), m_err[m], e.err);
    check_flag($sformatf("m%0d ack", m), m_ack[m], !e.err);
    if (e.rd) check_data($sformatf("m%0d read data", m), m_rdat[m], e.dat);
  endtask

  // Outputs are settled mid-cycle
  always @(negedge clk) begin
    for (int m = 0; m < 2; m++) begin
      if (m_ack[m] || m_err[m]) check_rsp(m);
    end
    if (s_stb[0] || s_stb[1]) stb_seen++;
  end

  // Queue the expected result, then hold the request until accepted
  task automatic issue(input int m, input logic we, input logic [AW-1:0] addr,
                       input logic [DW-1:0] dat, input logic [SW-1:0] sel);
    rsp_t          e;
    logic [DW-1:0] old_w;
    logic          taken;
    e = '0;
    if (!is_mapped(addr)) begin
      e.err = 1'b1;
    end else if (we) begin
      old_w = ref_mem.exists(addr) ? ref_mem[addr] : '0;
      ref_mem[addr] = merge_bytes(old_w, dat, sel);
    end else begin
      e.rd  = 1'b1;
      e.dat = ref_mem[addr];
    end
    if (m == 0) exp_q0.push_back(e);
    else exp_q1.push_back(e);
    m_cyc[m]  = 1'b1;
    m_stb[m]  = 1'b1;
    m_we[m]   = we;
    m_addr[m] = addr;
    m_wdat[m] = dat;
    m_sel[m]  = sel;
    taken = 1'b0;
    while (!taken) begin
      @(negedge clk);
      taken = !m_stall[m];
      @(posedge clk);
      #1;
    end
    m_stb[m] = 1'b0;
  endtask

  task automatic wait_done(input int m);
    int n;
    n = 0;
    do begin
      @(posedge clk);
      n++;
    end while (pending(m) != 0 && n < 1000);
    if (pending(m) != 0) begin
      $display("ERROR at %0t ns: master %0d timed out with %0d responses missing",
               $time, m, pending(m));
      errors++;
      if (m == 0) exp_q0.delete();
      else exp_q1.delete();
    end
    #1;
    m_cyc[m] = 1'b0;
  endtask

  task automatic report(input string name, input int errs_before);
    $display("[%0t ns] %s: %s", $time, name, (errors == errs_before) ? "passed" : "failed");
  endtask

  task automatic reset_idle();
    int e0;
    e0 = errors;
    repeat (5) begin
      @(negedge clk);
      for (int i = 0; i < 2; i++) begin
        check_flag($sformatf("m%0d ack after reset", i), m_ack[i], 1'b0);
        check_flag($sformatf("m%0d err after reset", i), m_err[i], 1'b0);
        check_flag($sformatf("s%0d cyc after reset", i), s_cyc[i], 1'b0);
        check_flag($sformatf("s%0d stb after reset", i), s_stb[i], 1'b0);
      end
    end
    @(posedge clk);
    #1;
    report("reset_idle", e0);
  endtask

  task automatic write_read_all();
    int            e0;
    logic [AW-1:0] a;
    logic [DW-1:0] d;
    e0 = errors;
    for (int m = 0; m < 2; m++) begin
      for (int w = 0; w < 2; w++) begin
        a = {w[3:0], 28'h000_0040} + AW'(4 * m);
        next_rand(d);
        issue(m, 1'b1, a, d, '1);
        issue(m, 1'b0, a, '0, '0);
      end
      wait_done(m);
    end
    report("write_read_all", e0);
  endtask

  task automatic byte_select_merge();
    int            e0;
    logic [AW-1:0] a;
    e0 = errors;
    for (int w = 0; w < 2; w++) begin
      a = {w[3:0], 28'h000_0080};
      issue(1, 1'b1, a, 32'h1122_3344, 4'hf);
      issue(1, 1'b1, a, 32'haabb_ccdd, 4'b0101);
      issue(1, 1'b1, a, 32'heeff_0099, 4'b1000);
      issue(1, 1'b0, a, '0, '0);
    end
    wait_done(1);
    report("byte_select_merge", e0);
  endtask

  task automatic unmapped_error();
    int e0;
    e0 = errors;
    stb_seen = 0;
    issue(0, 1'b0, 32'h2000_0010, '0, '0);
    issue(0, 1'b1, 32'hf000_0000, 32'hdead_beef, '1);
    wait_done(0);
    check_flag("slave stb on unmapped access", stb_seen != 0, 1'b0);
    report("unmapped_error", e0);
  endtask

  task automatic mixed_speed_order();
    int            e0;
    logic [DW-1:0] d;
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      next_rand(d);
      issue(0, 1'b1, 32'h0000_0100 + AW'(4 * i), d, '1);
      next_rand(d);
      issue(0, 1'b1, 32'h1000_0100 + AW'(4 * i), d, '1);
    end
    wait_done(0);
    s0_extra = 3'd4;
    for (int i = 0; i < 4; i++) begin
      issue(0, 1'b0, 32'h0000_0100 + AW'(4 * i), '0, '0);
      issue(0, 1'b0, 32'h1000_0100 + AW'(4 * i), '0, '0);
    end
    wait_done(0);
    s0_extra = 3'd0;
    report("mixed_speed_order", e0);
  endtask

  task automatic stream(input int m, input logic [AW-1:0] base);
    logic [DW-1:0] d;
    for (int i = 0; i < 8; i++) begin
      next_rand(d);
      issue(m, 1'b1, base + AW'(4 * i), d, '1);
      issue(m, 1'b0, base + AW'(4 * i), '0, '0);
    end
    wait_done(m);
  endtask

  task automatic dual_master_stream();
    int e0;
    e0 = errors;
    fork
      stream(0, 32'h1000_0200);
      stream(1, 32'h1000_0300);
    join
    report("dual_master_stream", e0);
  endtask

  initial begin
    for (int m = 0; m < 2; m++) begin
      m_addr[m] = '0;
      m_wdat[m] = '0;
      m_sel[m]  = '0;
      m_cyc[m]  = 1'b0;
      m_stb[m]  = 1'b0;
      m_we[m]   = 1'b0;
    end
    s0_extra   = 3'd0;
    data_state = SEED;
    errors     = 0;
    stb_seen   = 0;
    rst        = 1'b1;
    repeat (3) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_idle();
    write_read_all();
    byte_select_merge();
    unmapped_error();
    mixed_speed_order();
    dual_master_stream();
    $display("tests run: %0d, errors: %0d", NUM_TESTS, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // Generous bound per test
  initial begin
    #(NUM_TESTS * 2000);
    $display("ERROR: watchdog expired before the tests finished");
    $display("Test FAILED");
    $finish;
  end

endmodule

/* testbench/tb_wb_slave_model.sv */
// Wishbone pipelined slave memory model with random stall and ack latency
`include "wb_com_params.svh"

module tb_wb_slave_model (
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  logic [`WB_COM_AWIDTH-1:0]   addr_i,
  input  logic [`WB_COM_DWIDTH-1:0]   dat_i,
  input  logic [`WB_COM_DWIDTH/8-1:0] sel_i,
  input  logic                        cyc_i,
  input  logic                        stb_i,
  input  logic                        we_i,
  input  logic [7:0]                  rnd_i,
  input  logic [2:0]                  extra_lat_i,
  output logic [`WB_COM_DWIDTH-1:0]   dat_o,
  output logic                        stall_o,
  output logic                        ack_o
);
  timeunit 1ns;
  timeprecision 100ps;

  logic [`WB_COM_DWIDTH-1:0] mem [1024];
  logic [`WB_COM_DWIDTH-1:0] word;
  logic                      busy;
  logic                      stall_q;
  logic [3:0]                cnt;

  // Fill pattern built from the word index
  initial begin
    for (int i = 0; i < 1024; i++) mem[i] = {6'h2a, i[9:0], ~i[15:0]};
    busy    = 1'b0;
    stall_q = 1'b0;
    ack_o   = 1'b0;
    cnt     = '0;
    dat_o   = '0;
  end

  // One request in service at a time
  assign stall_o = busy || stall_q;

  always @(posedge clk_i) begin
    if (rst_i) begin
      busy    <= 1'b0;
      stall_q <= 1'b0;
      ack_o   <= 1'b0;
      cnt     <= '0;
    end else begin
      ack_o   <= 1'b0;
      stall_q <= (rnd_i[2:0] == 3'd0);
      if (busy) begin
        if (cnt == 4'd0) begin
          ack_o <= 1'b1;
          busy  <= 1'b0;
        end else begin
          cnt <= cnt - 4'd1;
        end
      end else if (cyc_i && stb_i && !stall_o) begin
        busy <= 1'b1;
        // Base latency of 1 to 4 cycles, plus the slow-down input
        cnt  <= {2'b00, rnd_i[4:3]} + {1'b0, extra_lat_i};
        word = mem[addr_i[11:2]];
        for (int b = 0; b < `WB_COM_DWIDTH / 8; b++) begin
          if (we_i && sel_i[b]) word[8*b +: 8] = dat_i[8*b +: 8];
        end
        mem[addr_i[11:2]] <= word;
        dat_o <= word;
      end
    end
  end

endmodule

/* hdl/wb_com_top.sv */
// Two-master two-slave Wishbone pipelined interconnect with in-order responses
`include "wb_com_params.svh"

module wb_com_top
  import wb_com_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  // Master 0
  input  logic [`WB_COM_AWIDTH-1:0]   m0_wb_addr_i,
  input  logic [`WB_COM_DWIDTH-1:0]   m0_wb_dat_i,
  input  logic [`WB_COM_DWIDTH/8-1:0] m0_wb_sel_i,
  input  logic                        m0_wb_cyc_i,
  input  logic                        m0_wb_stb_i,
  input  logic                        m0_wb_we_i,
  output logic [`WB_COM_DWIDTH-1:0]   m0_wb_dat_o,
  output logic                        m0_wb_stall_o,
  output logic                        m0_wb_ack_o,
  output logic                        m0_wb_err_o,
  // Master 1
  input  logic [`WB_COM_AWIDTH-1:0]   m1_wb_addr_i,
  input  logic [`WB_COM_DWIDTH-1:0]   m1_wb_dat_i,
  input  logic [`WB_COM_DWIDTH/8-1:0] m1_wb_sel_i,
  input  logic                        m1_wb_cyc_i,
  input  logic                        m1_wb_stb_i,
  input  logic                        m1_wb_we_i,
  output logic [`WB_COM_DWIDTH-1:0]   m1_wb_dat_o,
  output logic                        m1_wb_stall_o,
  output logic                        m1_wb_ack_o,
  output logic                        m1_wb_err_o,
  // Slave 0
  output logic [`WB_COM_AWIDTH-1:0]   s0_wb_addr_o,
  output logic [`WB_COM_DWIDTH-1:0]   s0_wb_dat_o,
  output logic [`WB_COM_DWIDTH/8-1:0] s0_wb_sel_o,
  output logic                        s0_wb_cyc_o,
  output logic                        s0_wb_stb_o,
  output logic                        s0_wb_we_o,
  input  logic [`WB_COM_DWIDTH-1:0]   s0_wb_dat_i,
  input  logic                        s0_wb_stall_i,
  input  logic                        s0_wb_ack_i,
  // Slave 1
  output logic [`WB_COM_AWIDTH-1:0]   s1_wb_addr_o,
  output logic [`WB_COM_DWIDTH-1:0]   s1_wb_dat_o,
  output logic [`WB_COM_DWIDTH/8-1:0] s1_wb_sel_o,
  output logic                        s1_wb_cyc_o,
  output logic                        s1_wb_stb_o,
  output logic                        s1_wb_we_o,
  input  logic [`WB_COM_DWIDTH-1:0]   s1_wb_dat_i,
  input  logic                        s1_wb_stall_i,
  input  logic                        s1_wb_ack_i
);

  wb_com_tag_t               time_tag;
  logic [`WB_COM_DWIDTH-1:0] s0_m0_rsp_dat;
  logic [`WB_COM_DWIDTH-1:0] s0_m1_rsp_dat;
  logic [`WB_COM_DWIDTH-1:0] s1_m0_rsp_dat;
  logic [`WB_COM_DWIDTH-1:0] s1_m1_rsp_dat;
  logic                      s0_m0_rsp_empty;
  logic                      s0_m1_rsp_empty;
  logic                      s1_m0_rsp_empty;
  logic                      s1_m1_rsp_empty;
  logic                      s0_m0_rsp_rd;
  logic                      s0_m1_rsp_rd;
  logic                      s1_m0_rsp_rd;
  logic                      s1_m1_rsp_rd;

  // Request queues, named master then slave
  wb_com_req_if m0_s0_if ();
  wb_com_req_if m0_s1_if ();
  wb_com_req_if m1_s0_if ();
  wb_com_req_if m1_s1_if ();

  // Same-cycle accepts on both masters share one tag
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      time_tag <= '0;
    end else if ((m0_wb_cyc_i && m0_wb_stb_i && !m0_wb_stall_o) ||
                 (m1_wb_cyc_i && m1_wb_stb_i && !m1_wb_stall_o)) begin
      time_tag <= time_tag + 1'b1;
    end
  end

  wb_com_master u_m0 (
    .clk_i, .rst_i, .time_tag_i(time_tag),
    .wb_addr_i(m0_wb_addr_i), .wb_dat_i(m0_wb_dat_i), .wb_sel_i(m0_wb_sel_i),
    .wb_cyc_i(m0_wb_cyc_i), .wb_stb_i(m0_wb_stb_i), .wb_we_i(m0_wb_we_i),
    .wb_dat_o(m0_wb_dat_o), .wb_stall_o(m0_wb_stall_o),
    .wb_ack_o(m0_wb_ack_o), .wb_err_o(m0_wb_err_o),
    .to_s0(m0_s0_if.src), .to_s1(m0_s1_if.src),
    .s0_rsp_dat_i(s0_m0_rsp_dat), .s0_rsp_empty_i(s0_m0_rsp_empty), .s0_rsp_rd_o(s0_m0_rsp_rd),
    .s1_rsp_dat_i(s1_m0_rsp_dat), .s1_rsp_empty_i(s1_m0_rsp_empty), .s1_rsp_rd_o(s1_m0_rsp_rd)
  );

  wb_com_master u_m1 (
    .clk_i, .rst_i, .time_tag_i(time_tag),
    .wb_addr_i(m1_wb_addr_i), .wb_dat_i(m1_wb_dat_i), .wb_sel_i(m1_wb_sel_i),
    .wb_cyc_i(m1_wb_cyc_i), .wb_stb_i(m1_wb_stb_i), .wb_we_i(m1_wb_we_i),
    .wb_dat_o(m1_wb_dat_o), .wb_stall_o(m1_wb_stall_o),
    .wb_ack_o(m1_wb_ack_o), .wb_err_o(m1_wb_err_o),
    .to_s0(m1_s0_if.src), .to_s1(m1_s1_if.src),
    .s0_rsp_dat_i(s0_m1_rsp_dat), .s0_rsp_empty_i(s0_m1_rsp_empty), .s0_rsp_rd_o(s0_m1_rsp_rd),
    .s1_rsp_dat_i(s1_m1_rsp_dat), .s1_rsp_empty_i(s1_m1_rsp_empty), .s1_rsp_rd_o(s1_m1_rsp_rd)
  );

  wb_com_slave u_s0 (
    .clk_i, .rst_i,
    .from_m0(m0_s0_if.dst), .from_m1(m1_s0_if.dst),
    .wb_addr_o(s0_wb_addr_o), .wb_dat_o(s0_wb_dat_o), .wb_sel_o(s0_wb_sel_o),
    .wb_cyc_o(s0_wb_cyc_o), .wb_stb_o(s0_wb_stb_o), .wb_we_o(s0_wb_we_o),
    .wb_dat_i(s0_wb_dat_i), .wb_stall_i(s0_wb_stall_i), .wb_ack_i(s0_wb_ack_i),
    .m0_rsp_dat_o(s0_m0_rsp_dat), .m0_rsp_empty_o(s0_m0_rsp_empty), .m0_rsp_rd_i(s0_m0_rsp_rd),
    .m1_rsp_dat_o(s0_m1_rsp_dat), .m1_rsp_empty_o(s0_m1_rsp_empty), .m1_rsp_rd_i(s0_m1_rsp_rd)
  );

  wb_com_slave u_s1 (
    .clk_i, .rst_i,
    .from_m0(m0_s1_if.dst), .from_m1(m1_s1_if.dst),
    .wb_addr_o(s1_wb_addr_o), .wb_dat_o(s1_wb_dat_o), .wb_sel_o(s1_wb_sel_o),
    .wb_cyc_o(s1_wb_cyc_o), .wb_stb_o(s1_wb_stb_o), .wb_we_o(s1_wb_we_o),
    .wb_dat_i(s1_wb_dat_i), .wb_stall_i(s1_wb_stall_i), .wb_ack_i(s1_wb_ack_i),
    .m0_rsp_dat_o(s1_m0_rsp_dat), .m0_rsp_empty_o(s1_m0_rsp_empty), .m0_rsp_rd_i(s1_m0_rsp_rd),
    .m1_rsp_dat_o(s1_m1_rsp_dat), .m1_rsp_empty_o(s1_m1_rsp_empty), .m1_rsp_rd_i(s1_m1_rsp_rd)
  );

endmodule

/* hdl/wb_com_slave.sv */
// Slave side: tag arbitration, Wishbone issue and response routing back to masters
`include "wb_com_params.svh"

module wb_com_slave
  import wb_com_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  wb_com_req_if.dst                   from_m0,
  wb_com_req_if.dst                   from_m1,
  output logic [`WB_COM_AWIDTH-1:0]   wb_addr_o,
  output logic [`WB_COM_DWIDTH-1:0]   wb_dat_o,
  output logic [`WB_COM_DWIDTH/8-1:0] wb_sel_o,
  output logic                        wb_cyc_o,
  output logic                        wb_stb_o,
  output logic                        wb_we_o,
  input  logic [`WB_COM_DWIDTH-1:0]   wb_dat_i,
  input  logic                        wb_stall_i,
  input  logic                        wb_ack_i,
  output logic [`WB_COM_DWIDTH-1:0]   m0_rsp_dat_o,
  output logic                        m0_rsp_empty_o,
  input  logic                        m0_rsp_rd_i,
  output logic [`WB_COM_DWIDTH-1:0]   m1_rsp_dat_o,
  output logic                        m1_rsp_empty_o,
  input  logic                        m1_rsp_rd_i
);

  wb_com_tag_t               tag_diff;
  wb_com_hdr_t               hdr_n;
  wb_com_hdr_t               hdr_q;
  logic [`WB_COM_DWIDTH-1:0] dat_n;
  logic [`WB_COM_DWIDTH-1:0] dat_q;
  logic                      pick_m1;
  logic                      load;
  logic                      stb_q;
  logic                      src_full;
  logic                      src_empty;
  logic                      src_m1;

  // Negative wrap-around difference means the m1 request is older
  assign tag_diff = from_m1.hdr.tag - from_m0.hdr.tag;
  assign pick_m1  = !from_m1.empty && (from_m0.empty || tag_diff[`WB_COM_TAG_W-1]);

  // Load when the output register is free or leaving this cycle
  assign load = (!from_m0.empty || !from_m1.empty) && !src_full && (!stb_q || !wb_stall_i);
  assign from_m0.rd = load && !pick_m1;
  assign from_m1.rd = load && pick_m1;

  assign {hdr_n, dat_n} = pick_m1 ? {from_m1.hdr, from_m1.dat} : {from_m0.hdr, from_m0.dat};

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      stb_q <= 1'b0;
    end else if (load) begin
      stb_q <= 1'b1;
    end else if (!wb_stall_i) begin
      stb_q <= 1'b0;
    end
  end

  // Request payload held until accepted
  always_ff @(posedge clk_i) begin
    if (load) begin
      hdr_q <= hdr_n;
      dat_q <= dat_n;
    end
  end

  assign wb_stb_o  = stb_q;
  assign wb_addr_o = hdr_q.addr;
  assign wb_sel_o  = hdr_q.sel;
  assign wb_we_o   = hdr_q.we;
  assign wb_dat_o  = dat_q;
  // Source entry lives from load until ack, so it covers stb too
  assign wb_cyc_o  = !src_empty;

  // Which master each loaded request came from
  wb_com_fifo #(.WIDTH(1), .ASIZE(`WB_COM_F_ASIZE)) u_src (
    .clk_i, .rst_i,
    .wr_i(load), .wdata_i(pick_m1),
    .rd_i(wb_ack_i), .rdata_o(src_m1), .full_o(src_full), .empty_o(src_empty)
  );

  wb_com_fifo #(.WIDTH(`WB_COM_DWIDTH), .ASIZE(`WB_COM_F_ASIZE)) u_rsp_m0 (
    .clk_i, .rst_i,
    .wr_i(wb_ack_i && !src_m1), .wdata_i(wb_dat_i),
    .rd_i(m0_rsp_rd_i), .rdata_o(m0_rsp_dat_o), .full_o(), .empty_o(m0_rsp_empty_o)
  );

  wb_com_fifo #(.WIDTH(`WB_COM_DWIDTH), .ASIZE(`WB_COM_F_ASIZE)) u_rsp_m1 (
    .clk_i, .rst_i,
    .wr_i(wb_ack_i && src_m1), .wdata_i(wb_dat_i),
    .rd_i(m1_rsp_rd_i), .rdata_o(m1_rsp_dat_o), .full_o(), .empty_o(m1_rsp_empty_o)
  );

  // Device must not answer a request it never received
  a_ack_outstanding: assert property (@(posedge clk_i) disable iff (rst_i)
    wb_ack_i |-> !src_empty)
    else $error("wb_com_slave: ack with no request outstanding");

endmodule

/* hdl/wb_com_master.sv */
// Master side: address decode, per-slave request queues and in-order response return
`include "wb_com_params.svh"

module wb_com_master
  import wb_com_pkg::*;
(
  input  logic                        clk_i,
  input  logic                        rst_i,
  input  wb_com_tag_t                 time_tag_i,
  input  logic [`WB_COM_AWIDTH-1:0]   wb_addr_i,
  input  logic [`WB_COM_DWIDTH-1:0]   wb_dat_i,
  input  logic [`WB_COM_DWIDTH/8-1:0] wb_sel_i,
  input  logic                        wb_cyc_i,
  input  logic                        wb_stb_i,
  input  logic                        wb_we_i,
  output logic [`WB_COM_DWIDTH-1:0]   wb_dat_o,
  output logic                        wb_stall_o,
  output logic                        wb_ack_o,
  output logic                        wb_err_o,
  wb_com_req_if.src                   to_s0,
  wb_com_req_if.src                   to_s1,
  input  logic [`WB_COM_DWIDTH-1:0]   s0_rsp_dat_i,
  input  logic                        s0_rsp_empty_i,
  output logic                        s0_rsp_rd_o,
  input  logic [`WB_COM_DWIDTH-1:0]   s1_rsp_dat_i,
  input  logic                        s1_rsp_empty_i,
  output logic                        s1_rsp_rd_o
);

  localparam int REQ_W = $bits(wb_com_hdr_t) + `WB_COM_DWIDTH;
  localparam int TGT_W = $bits(wb_com_target_e);

  wb_com_target_e   tgt;
  wb_com_target_e   head;
  wb_com_hdr_t      req_hdr;
  logic             acc;
  logic             s0_full;
  logic             s1_full;
  logic             ord_full;
  logic             ord_empty;
  logic [TGT_W-1:0] ord_q;
  logic [REQ_W-1:0] s0_q;
  logic [REQ_W-1:0] s1_q;
  logic             rsp_ready;
  logic             ret;

  // Decode by masked compare against each window
  always_comb begin
    if ((wb_addr_i & `WB_COM_S0_AMASK) == `WB_COM_S0_ABASE) tgt = TGT_S0;
    else if ((wb_addr_i & `WB_COM_S1_AMASK) == `WB_COM_S1_ABASE) tgt = TGT_S1;
    else tgt = TGT_NONE;
  end

  assign wb_stall_o = ord_full || (tgt == TGT_S0 && s0_full) || (tgt == TGT_S1 && s1_full);
  assign acc        = wb_cyc_i && wb_stb_i && !wb_stall_o;
  assign req_hdr    = '{addr: wb_addr_i, tag: time_tag_i, sel: wb_sel_i, we: wb_we_i};

  // Header and write data share one entry
  wb_com_fifo #(.WIDTH(REQ_W), .ASIZE(`WB_COM_F_ASIZE)) u_s0_req (
    .clk_i, .rst_i,
    .wr_i(acc && tgt == TGT_S0), .wdata_i({req_hdr, wb_dat_i}),
    .rd_i(to_s0.rd), .rdata_o(s0_q), .full_o(s0_full), .empty_o(to_s0.empty)
  );
  assign {to_s0.hdr, to_s0.dat} = s0_q;

  wb_com_fifo #(.WIDTH(REQ_W), .ASIZE(`WB_COM_F_ASIZE)) u_s1_req (
    .clk_i, .rst_i,
    .wr_i(acc && tgt == TGT_S1), .wdata_i({req_hdr, wb_dat_i}),
    .rd_i(to_s1.rd), .rdata_o(s1_q), .full_o(s1_full), .empty_o(to_s1.empty)
  );
  assign {to_s1.hdr, to_s1.dat} = s1_q;

  // Acceptance order, unmapped requests included
  wb_com_fifo #(.WIDTH(TGT_W), .ASIZE(`WB_COM_F_ASIZE)) u_order (
    .clk_i, .rst_i,
    .wr_i(acc), .wdata_i(tgt),
    .rd_i(ret), .rdata_o(ord_q), .full_o(ord_full), .empty_o(ord_empty)
  );
  assign head = wb_com_target_e'(ord_q);

  // Result stage waits for the response of the oldest request
  always_comb begin
    case (head)
      TGT_S0:  rsp_ready = !s0_rsp_empty_i;
      TGT_S1:  rsp_ready = !s1_rsp_empty_i;
      default: rsp_ready = 1'b1;
    endcase
  end

  assign ret         = !ord_empty && rsp_ready;
  assign s0_rsp_rd_o = ret && head == TGT_S0;
  assign s1_rsp_rd_o = ret && head == TGT_S1;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_ack_o <= 1'b0;
      wb_err_o <= 1'b0;
    end else begin
      wb_ack_o <= ret && head != TGT_NONE;
      wb_err_o <= ret && head == TGT_NONE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ret) wb_dat_o <= (head == TGT_S1) ? s1_rsp_dat_i : s0_rsp_dat_i;
  end

  // A waiting response always belongs to a request still in the order queue
  a_rsp_has_req: assert property (@(posedge clk_i) disable iff (rst_i)
    (!s0_rsp_empty_i || !s1_rsp_empty_i) |-> !ord_empty)
    else $error("wb_com_master: response with no request outstanding");

endmodule

/* hdl/wb_com_fifo.sv */
// Synchronous show-ahead FIFO with full and empty flags
module wb_com_fifo #(
  parameter int WIDTH = 32,
  parameter int ASIZE = 2
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  logic             wr_i,
  input  logic [WIDTH-1:0] wdata_i,
  input  logic             rd_i,
  output logic [WIDTH-1:0] rdata_o,
  output logic             full_o,
  output logic             empty_o
);

  localparam int DEPTH = 1 << ASIZE;

  logic [WIDTH-1:0] mem [DEPTH];
  // Extra top bit tells full from empty
  logic [ASIZE:0]   wr_ptr;
  logic [ASIZE:0]   rd_ptr;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (wr_i) wr_ptr <= wr_ptr + 1'b1;
      if (rd_i) rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_i) mem[wr_ptr[ASIZE-1:0]] <= wdata_i;
  end

  // Head entry is visible without a read strobe
  assign rdata_o = mem[rd_ptr[ASIZE-1:0]];
  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[ASIZE] != rd_ptr[ASIZE]) &&
                   (wr_ptr[ASIZE-1:0] == rd_ptr[ASIZE-1:0]);

  a_no_overflow: assert property (@(posedge clk_i) disable iff (rst_i) wr_i |-> !full_o)
    else $error("wb_com_fifo: push while full");
  a_no_underflow: assert property (@(posedge clk_i) disable iff (rst_i) rd_i |-> !empty_o)
    else $error("wb_com_fifo: pop while empty");

endmodule

/* hdl/wb_com_req_if.sv */
// Request queue head passed from a master side to a slave side
`include "wb_com_params.svh"

interface wb_com_req_if
  import wb_com_pkg::*;
();

  // hdr and dat are valid whenever empty is low
  wb_com_hdr_t               hdr;
  logic [`WB_COM_DWIDTH-1:0] dat;
  logic                      empty;
  // One-cycle pulse pops the head entry
  logic                      rd;

  modport src (
    output hdr,
    output dat,
    output empty,
    input  rd
  );

  modport dst (
    input  hdr,
    input  dat,
    input  empty,
    output rd
  );

endinterface

/* hdl/wb_com_pkg.sv */
// Shared types of the interconnect: time tag, request header and decode target
`include "wb_com_params.svh"

package wb_com_pkg;

  // Acceptance time tag, shared by both master sides
  typedef logic [`WB_COM_TAG_W-1:0] wb_com_tag_t;

  // Request header as queued toward a slave side
  typedef struct packed {
    logic [`WB_COM_AWIDTH-1:0]   addr;
    wb_com_tag_t                 tag;
    logic [`WB_COM_DWIDTH/8-1:0] sel;
    logic                        we;
  } wb_com_hdr_t;

  // Address decode result
  typedef enum logic [1:0] {
    TGT_S0,
    TGT_S1,
    TGT_NONE
  } wb_com_target_e;

endpackage

/* include/wb_com_params.svh */
// Interconnect parameters: bus widths, queue depth and slave address windows
`ifndef WB_COM_PARAMS_SVH
`define WB_COM_PARAMS_SVH

// Bus widths
`define WB_COM_AWIDTH 32
`define WB_COM_DWIDTH 32

// Log2 of every queue depth
`define WB_COM_F_ASIZE 2

// Wide enough that tags of waiting requests never alias
`define WB_COM_TAG_W (`WB_COM_F_ASIZE + 2)

// Slave address windows
`define WB_COM_S0_ABASE 32'h0000_0000
`define WB_COM_S0_AMASK 32'hF000_0000
`define WB_COM_S1_ABASE 32'h1000_0000
`define WB_COM_S1_AMASK 32'hF000_0000

`endif
